/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= video_gen_tb
FILELIST  ?= video_gen.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* video_bitmap_fetch.sv */
// 8 bpp bitmap playfield that tracks the line address, prefetches vram words and shifts out indices
`include "video_gen_settings.svh"

module video_bitmap_fetch
    import video_gen_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire hres_t      h_count_i,
    input  wire logic       v_visible_i,
    input  wire logic       end_of_line_i,
    input  wire logic       end_of_frame_i,
    input  wire color_t     border_color_i,
    input  wire hres_t      vid_left_i,
    input  wire hres_t      vid_right_i,
    input  wire color_t     pa_colorbase_i,
    input  wire logic       pa_blank_i,
    input  wire addr_t      pa_disp_addr_i,
    input  wire word_t      pa_line_len_i,
    input  wire word_t      vram_data_i,
    output      logic       vram_sel_o,
    output      addr_t      vram_addr_o,
    output      color_t     color_index_o
);

    localparam hres_t H_START     = hres_t'(`H_OFFSCREEN);
    localparam hres_t FETCH_START = hres_t'(`H_OFFSCREEN - `FETCH_LEAD);
    localparam hres_t FETCH_END   = hres_t'(`H_OFFSCREEN - `FETCH_LEAD + `H_VISIBLE);

    addr_t                          line_addr;      // word of column 0 on this line
    hres_t                          fetch_offset;   // clocks into the fetch window
    logic                           in_fetch;
    logic                           rd_pending;     // vram data valid this cycle
    word_t                          fetch_word;     // next word for the shifter
    word_t                          shifter;        // current pixel in high byte
    hres_t                          col;            // visible column at raw count
    logic                           col_visible;
    logic                           in_window;
    color_t                         pixel;
    color_t [`PIXEL_LATENCY-1:0]    pix_pipe;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr <= '0;
        end else if (end_of_frame_i) begin
            line_addr <= pa_disp_addr_i;
        end else if (end_of_line_i && v_visible_i) begin
            line_addr <= line_addr + pa_line_len_i;
        end
    end

    // one read every second clock across the window
    assign fetch_offset = h_count_i - FETCH_START;
    assign in_fetch     = v_visible_i && (h_count_i >= FETCH_START) && (h_count_i < FETCH_END);
    assign vram_sel_o   = in_fetch && !fetch_offset[0];
    assign vram_addr_o  = line_addr + addr_t'(fetch_offset[5:1]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= vram_sel_o;
        end
    end

    // shifter gives column x its byte at raw count H_START + x
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            fetch_word <= vram_data_i;
        end
        if (col[0]) begin
            shifter <= fetch_word;                  // next word after the odd column
        end else begin
            shifter <= {shifter[7:0], 8'h00};
        end
    end

    assign col         = h_count_i - H_START;
    assign col_visible = v_visible_i && (h_count_i >= H_START);
    assign in_window   = (col >= vid_left_i) && (col < vid_right_i);

    always_comb begin
        pixel = border_color_i;                     // border skips the colorbase xor
        if (col_visible && in_window && !pa_blank_i) begin
            pixel = shifter[15:8] ^ pa_colorbase_i;
        end
    end

    // match the delayed blanks from the timing block
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pix_pipe <= '0;
        end else begin
            pix_pipe <= {pix_pipe[`PIXEL_LATENCY-2:0], pixel};
        end
    end

    assign color_index_o = pix_pipe[`PIXEL_LATENCY-1];

    // reads stay inside the fetch window of a visible line
    assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> v_visible_i && (fetch_offset < hres_t'(`H_VISIBLE)));

endmodule

/* video_gen.f */
+incdir+.
video_gen_pkg.sv
video_timing.sv
video_regs.sv
video_bitmap_fetch.sv
video_gen.sv
video_gen_tb.sv

/* video_gen.sv */
// video generator top level joining raster timing, register bank and bitmap playfield
module video_gen
    import video_gen_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       wb_cyc_i,
    input  wire logic       wb_stb_i,
    input  wire logic       wb_we_i,
    input  wire reg_num_t   wb_adr_i,
    input  wire word_t      wb_dat_i,
    output      word_t      wb_dat_o,
    output      logic       wb_ack_o,
    output      logic       video_intr_o,
    output      logic       vram_sel_o,
    output      addr_t      vram_addr_o,
    input  wire word_t      vram_data_i,
    output      color_t     color_index_o,
    output      logic       h_blank_o,
    output      logic       v_blank_o,
    output      logic       hsync_o,
    output      logic       vsync_o,
    output      logic       dv_de_o
);

    hres_t      h_count;
    vres_t      v_count;
    logic       v_visible;
    logic       end_of_line;
    logic       end_of_frame;
    logic       end_of_visible;
    color_t     border_color;
    hres_t      vid_left;
    hres_t      vid_right;
    color_t     pa_colorbase;
    logic       pa_blank;
    addr_t      pa_disp_addr;
    word_t      pa_line_len;

    video_timing video_timing_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .h_count_o       (h_count),
        .v_count_o       (v_count),
        .h_visible_o     (),                    // fetch decodes columns itself
        .v_visible_o     (v_visible),
        .end_of_line_o   (end_of_line),
        .end_of_frame_o  (end_of_frame),
        .end_of_visible_o(end_of_visible),
        .h_blank_o       (h_blank_o),
        .v_blank_o       (v_blank_o),
        .hsync_o         (hsync_o),
        .vsync_o         (vsync_o),
        .dv_de_o         (dv_de_o)
    );

    video_regs video_regs_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_stb_i        (wb_stb_i),
        .wb_we_i         (wb_we_i),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .v_count_i       (v_count),
        .end_of_visible_i(end_of_visible),
        .wb_dat_o        (wb_dat_o),
        .wb_ack_o        (wb_ack_o),
        .video_intr_o    (video_intr_o),
        .border_color_o  (border_color),
        .vid_left_o      (vid_left),
        .vid_right_o     (vid_right),
        .pa_colorbase_o  (pa_colorbase),
        .pa_blank_o      (pa_blank),
        .pa_disp_addr_o  (pa_disp_addr),
        .pa_line_len_o   (pa_line_len)
    );

    video_bitmap_fetch video_bitmap_fetch_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .h_count_i       (h_count),
        .v_visible_i     (v_visible),
        .end_of_line_i   (end_of_line),
        .end_of_frame_i  (end_of_frame),
        .border_color_i  (border_color),
        .vid_left_i      (vid_left),
        .vid_right_i     (vid_right),
        .pa_colorbase_i  (pa_colorbase),
        .pa_blank_i      (pa_blank),
        .pa_disp_addr_i  (pa_disp_addr),
        .pa_line_len_i   (pa_line_len),
        .vram_data_i     (vram_data_i),
        .vram_sel_o      (vram_sel_o),
        .vram_addr_o     (vram_addr_o),
        .color_index_o   (color_index_o)
    );

endmodule

/* video_gen_pkg.sv */
// shared data types of the video generator, imported by the RTL modules and the testbench
package video_gen_pkg;

    typedef logic [15:0] word_t;        // bus and vram data
    typedef logic [15:0] addr_t;        // vram word address
    typedef logic [7:0]  color_t;       // palette index
    typedef logic [5:0]  hres_t;        // horizontal count
    typedef logic [3:0]  vres_t;        // vertical count
    typedef logic [3:0]  reg_num_t;

    // host visible register numbers
    typedef enum reg_num_t {
        VID_CTRL     = 4'h0,
        VID_INTR     = 4'h1,
        VID_LEFT     = 4'h2,
        VID_RIGHT    = 4'h3,
        SCANLINE     = 4'h4,            // read only
        VID_HSIZE    = 4'h5,            // read only
        VID_VSIZE    = 4'h6,            // read only
        PA_GFX_CTRL  = 4'h8,
        PA_DISP_ADDR = 4'h9,
        PA_LINE_LEN  = 4'hA
    } reg_num_e;

    // playfield control word, either as bus data or as its fields
    typedef union packed {
        word_t raw;
        struct packed {
            color_t     colorbase;      // xor applied to every bitmap pixel
            logic       blank;          // playfield off, border only
            logic [6:0] unused;
        } f;
    } gfx_ctrl_u;

endpackage

/* video_gen_settings.svh */
// raster geometry and pixel pipeline constants, included by the video RTL and its testbench
`ifndef VIDEO_GEN_SETTINGS_SVH
`define VIDEO_GEN_SETTINGS_SVH

// horizontal timing in pixel clocks, blanking comes first in the line
`define H_FRONT         4
`define H_SYNC          4
`define H_BACK          8
`define H_VISIBLE       32
`define H_OFFSCREEN     (`H_FRONT + `H_SYNC + `H_BACK)
`define H_TOTAL         (`H_OFFSCREEN + `H_VISIBLE)

// vertical timing in lines, same order
`define V_FRONT         1
`define V_SYNC          1
`define V_BACK          2
`define V_VISIBLE       8
`define V_OFFSCREEN     (`V_FRONT + `V_SYNC + `V_BACK)
`define V_TOTAL         (`V_OFFSCREEN + `V_VISIBLE)

// pixel path
`define FETCH_LEAD      4       // first vram read, clocks ahead of column 0
`define PIXEL_LATENCY   3       // clocks from raw counters to pixel out

`endif

/* video_gen_tb.sv */
// self-checking testbench for video_gen running register bus tests and a per-pixel frame compare
`include "video_gen_settings.svh"

module video_gen_tb
    import video_gen_pkg::*;
();

    localparam int FRAME_PIXELS = `H_VISIBLE * `V_VISIBLE;
    localparam int CYCLE_LIMIT  = 8 * `H_TOTAL * `V_TOTAL + 200;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_we_i;
    reg_num_t   wb_adr_i;
    word_t      wb_dat_i;
    word_t      wb_dat_o;
    logic       wb_ack_o;
    logic       video_intr_o;
    logic       vram_sel_o;
    addr_t      vram_addr_o;
    word_t      vram_data_i;
    color_t     color_index_o;
    logic       h_blank_o;
    logic       v_blank_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    // host side copies of the display registers
    color_t     border_c    = 8'h08;
    hres_t      left_c      = '0;
    hres_t      right_c     = hres_t'(`H_VISIBLE);
    color_t     colorbase_c = '0;
    logic       blank_c     = 1'b1;
    addr_t      disp_c      = '0;
    word_t      line_len_c  = 16'd16;
    addr_t      loaded_addr = '0;           // display address latched at frame end

    logic [31:0] lfsr_state = 32'h9391_eaa7;
    int         cycles      = 0;
    int         err_pixel   = 0;
    int         err_reg     = 0;
    int         err_other   = 0;
    int         bus_count   = 0;
    int         ack_count   = 0;
    int         intr_count  = 0;
    int         intr_writes = 0;
    int         frame_count = 0;
    int         pix_count   = 0;
    int         col_n       = 0;
    int         row_n       = 0;
    int         hpos        = -1;           // clocks since the delayed line start
    int         vline       = -1;           // lines since the delayed frame start
    logic       prev_hb     = 1'b1;
    logic       prev_vb     = 1'b1;

    always #2 clk = ~clk;

    video_gen video_gen_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .video_intr_o (video_intr_o),
        .vram_sel_o   (vram_sel_o),
        .vram_addr_o  (vram_addr_o),
        .vram_data_i  (vram_data_i),
        .color_index_o(color_index_o),
        .h_blank_o    (h_blank_o),
        .v_blank_o    (v_blank_o),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .dv_de_o      (dv_de_o)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic color_t expected_pixel(input int x, input int row);
        addr_t a;
        word_t w;
        if (blank_c || x < int'(left_c) || x >= int'(right_c)) begin
            return border_c;                        // border without the xor
        end
        a = loaded_addr + addr_t'(row) * line_len_c + addr_t'(x / 2);
        w = a ^ 16'hA5C3;                           // what the vram model returns
        return (x % 2 == 0) ? (w[15:8] ^ colorbase_c) : (w[7:0] ^ colorbase_c);
    endfunction

    task automatic check_color(input string what, input color_t got, input color_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", what, got, exp);
            err_pixel++;
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", what, got, exp);
            err_reg++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("Fail %s: got %h, expected %h", what, got, exp);
            err_other++;
        end
    endtask

    task automatic wb_write(input reg_num_e adr, input word_t data);
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = data;
        bus_count++;
        @(negedge clk);
        while (!wb_ack_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        case (adr)                                  // register took the word on the ack edge
            VID_CTRL:     border_c = data[7:0];
            VID_INTR:     intr_writes++;
            VID_LEFT:     left_c = data[5:0];
            VID_RIGHT:    right_c = data[5:0];
            PA_GFX_CTRL: begin
                colorbase_c = data[15:8];
                blank_c     = data[7];
            end
            PA_DISP_ADDR: disp_c = data;
            PA_LINE_LEN:  line_len_c = data;
            default: begin
            end
        endcase
    endtask

    task automatic wb_read(input reg_num_e adr, output word_t data);
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        bus_count++;
        @(negedge clk);
        while (!wb_ack_o) begin
            @(negedge clk);
        end
        data = wb_dat_o;
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic readback_random(input reg_num_e adr, input word_t mask);
        word_t v;
        word_t rd;
        v = rand_bits(16);
        wb_write(adr, v);
        wb_read(adr, rd);
        check_word($sformatf("wb_dat_o %s", adr.name()), rd, v & mask);
    endtask

    // returns once the delayed vertical blank has just started
    task automatic wait_vblank_start();
        @(negedge clk);
        while (v_blank_o) begin
            @(negedge clk);
        end
        while (!v_blank_o) begin
            @(negedge clk);
        end
    endtask

    // vram model returning data one clock after sel
    initial begin
        logic  req;
        addr_t req_addr;
        vram_data_i = '0;
        forever begin
            @(negedge clk);
            req      = vram_sel_o;
            req_addr = vram_addr_o;
            @(posedge clk);
            #1;
            vram_data_i = req ? (req_addr ^ 16'hA5C3) : 16'h0000;
        end
    end

    // compare process following columns and rows from the delayed blanks
    always @(negedge clk) begin
        if (!reset_i) begin
            if (wb_ack_o) begin
                ack_count++;
            end
            if (video_intr_o) begin
                intr_count++;
            end
            if (h_blank_o && !prev_hb) begin
                hpos = 0;                           // delayed h_count back at 0
                if (v_blank_o && !prev_vb) begin
                    vline = 0;
                end else if (vline >= 0) begin
                    vline++;
                end
            end else if (hpos >= 0) begin
                hpos++;
            end
            if (hpos >= 0 && vline >= 0) begin
                check_count("h_blank_o", int'(h_blank_o), int'(hpos < `H_OFFSCREEN));
                check_count("v_blank_o", int'(v_blank_o), int'(vline < `V_OFFSCREEN));
                check_count("hsync_o", int'(hsync_o),
                            int'(hpos >= `H_FRONT && hpos < `H_FRONT + `H_SYNC));
                check_count("vsync_o", int'(vsync_o),
                            int'(vline >= `V_FRONT && vline < `V_FRONT + `V_SYNC));
                check_count("dv_de_o", int'(dv_de_o),
                            int'(hpos >= `H_OFFSCREEN && vline >= `V_OFFSCREEN));
            end
            if (v_blank_o) begin
                if (!prev_vb) begin
                    frame_count++;
                    loaded_addr = disp_c;           // reload at end of frame
                end
                row_n = -1;
                col_n = 0;
            end else if (h_blank_o) begin
                col_n = 0;
            end else begin
                if (prev_hb) begin
                    row_n++;                        // first column of a new line
                end
                check_color($sformatf("color_index_o col %0d row %0d", col_n, row_n),
                            color_index_o, expected_pixel(col_n, row_n));
                pix_count++;
                col_n++;
            end
            prev_vb = v_blank_o;
            prev_hb = h_blank_o;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        word_t rd;
        word_t v;
        reset_i  = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (8) @(posedge clk);
        #1;
        reset_i = 1'b0;

        wb_read(VID_CTRL, rd);
        check_word("wb_dat_o VID_CTRL", rd, 16'h0008);
        wb_read(VID_RIGHT, rd);
        check_word("wb_dat_o VID_RIGHT", rd, word_t'(`H_VISIBLE));
        wb_read(PA_GFX_CTRL, rd);
        check_word("wb_dat_o PA_GFX_CTRL", rd, 16'h0080);   // colorbase 0, blank set
        wb_read(PA_LINE_LEN, rd);
        check_word("wb_dat_o PA_LINE_LEN", rd, 16'd16);
        wb_read(VID_HSIZE, rd);
        check_word("wb_dat_o VID_HSIZE", rd, word_t'(`H_VISIBLE));
        wb_read(VID_VSIZE, rd);
        check_word("wb_dat_o VID_VSIZE", rd, word_t'(`V_VISIBLE));

        wait_vblank_start();
        wb_read(SCANLINE, rd);
        if (rd >= word_t'(`V_OFFSCREEN)) begin      // blank lines come first in the frame
            $display("Fail wb_dat_o SCANLINE: got %h, expected below %h", rd, `V_OFFSCREEN);
            err_reg++;
        end
        readback_random(VID_CTRL, 16'h00FF);
        readback_random(VID_LEFT, 16'h003F);
        readback_random(VID_RIGHT, 16'h003F);
        readback_random(PA_GFX_CTRL, 16'hFF80);
        readback_random(PA_DISP_ADDR, 16'hFFFF);
        readback_random(PA_LINE_LEN, 16'hFFFF);

        wait_vblank_start();
        wb_write(VID_LEFT, 16'h0000);
        wb_write(VID_RIGHT, word_t'(`H_VISIBLE));
        v = rand_bits(8);
        wb_write(PA_GFX_CTRL, {v[7:0], 8'h00});
        wb_write(PA_DISP_ADDR, rand_bits(16));
        wb_write(PA_LINE_LEN, rand_bits(16));
        wait_vblank_start();                        // new start address shows from here

        wait_vblank_start();
        v = rand_bits(3);
        wb_write(VID_LEFT, 16'd2 + v);
        v = rand_bits(3);
        wb_write(VID_RIGHT, 16'd24 + v);
        wb_write(VID_CTRL, rand_bits(8));

        wait_vblank_start();
        wb_write(PA_GFX_CTRL, {colorbase_c, 1'b1, 7'h00});
        wb_write(VID_INTR, 16'h0000);
        wait_vblank_start();
        repeat (2) @(posedge clk);

        check_count("video_intr_o pulses", intr_count, frame_count + intr_writes);
        check_count("wb_ack_o pulses", ack_count, bus_count);
        check_count("visible pixels compared", pix_count, frame_count * FRAME_PIXELS);
        $display("errors: pixel %0d, register %0d, other %0d", err_pixel, err_reg, err_other);
        if (err_pixel + err_reg + err_other == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* video_regs.sv */
// Wishbone classic slave holding the video configuration registers and the frame interrupt
`include "video_gen_settings.svh"

module video_regs
    import video_gen_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       wb_cyc_i,
    input  wire logic       wb_stb_i,
    input  wire logic       wb_we_i,
    input  wire reg_num_t   wb_adr_i,
    input  wire word_t      wb_dat_i,
    input  wire vres_t      v_count_i,
    input  wire logic       end_of_visible_i,
    output      word_t      wb_dat_o,
    output      logic       wb_ack_o,
    output      logic       video_intr_o,
    output      color_t     border_color_o,
    output      hres_t      vid_left_o,
    output      hres_t      vid_right_o,
    output      color_t     pa_colorbase_o,
    output      logic       pa_blank_o,
    output      addr_t      pa_disp_addr_o,
    output      word_t      pa_line_len_o
);

    logic       bus_req;                // new access not yet acked
    logic       bus_wr;
    reg_num_e   reg_sel;
    gfx_ctrl_u  wr_ctrl;                // bus word split into fields
    gfx_ctrl_u  rd_ctrl;
    word_t      rd_data;

    assign bus_req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign bus_wr      = bus_req && wb_we_i;
    assign reg_sel     = reg_num_e'(wb_adr_i);
    assign wr_ctrl.raw = wb_dat_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o       <= 1'b0;
            video_intr_o   <= 1'b0;
            border_color_o <= 8'h08;                // dark grey
            vid_left_o     <= '0;
            vid_right_o    <= hres_t'(`H_VISIBLE);
            pa_colorbase_o <= '0;
            pa_blank_o     <= 1'b1;                 // playfield starts off
            pa_disp_addr_o <= '0;
            pa_line_len_o  <= word_t'(`H_VISIBLE / 2);   // one line of 8 bpp words
        end else begin
            wb_ack_o     <= bus_req;
            video_intr_o <= end_of_visible_i || (bus_wr && reg_sel == VID_INTR);
            if (bus_wr) begin
                case (reg_sel)
                    VID_CTRL:     border_color_o <= wb_dat_i[7:0];
                    VID_LEFT:     vid_left_o     <= hres_t'(wb_dat_i);
                    VID_RIGHT:    vid_right_o    <= hres_t'(wb_dat_i);
                    PA_GFX_CTRL: begin
                        pa_colorbase_o <= wr_ctrl.f.colorbase;
                        pa_blank_o     <= wr_ctrl.f.blank;
                    end
                    PA_DISP_ADDR: pa_disp_addr_o <= wb_dat_i;
                    PA_LINE_LEN:  pa_line_len_o  <= wb_dat_i;
                    default: begin
                    end
                endcase
            end
        end
    end

    // read-back mux
    always_comb begin
        rd_ctrl.raw         = '0;
        rd_ctrl.f.colorbase = pa_colorbase_o;
        rd_ctrl.f.blank     = pa_blank_o;
        rd_data             = '0;                   // unused numbers read 0
        case (reg_sel)
            VID_CTRL:     rd_data = {8'h00, border_color_o};
            VID_LEFT:     rd_data = word_t'(vid_left_o);
            VID_RIGHT:    rd_data = word_t'(vid_right_o);
            SCANLINE:     rd_data = word_t'(v_count_i);     // live line
            VID_HSIZE:    rd_data = word_t'(`H_VISIBLE);
            VID_VSIZE:    rd_data = word_t'(`V_VISIBLE);
            PA_GFX_CTRL:  rd_data = rd_ctrl.raw;
            PA_DISP_ADDR: rd_data = pa_disp_addr_o;
            PA_LINE_LEN:  rd_data = pa_line_len_o;
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus_req && !wb_we_i) begin
            wb_dat_o <= rd_data;                    // valid with ack
        end
    end

    // ack lasts a single clock
    assert property (@(posedge clk) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

/* video_timing.sv */
// raster counters with sync, blank and event decode; blank and sync leave delayed to match pixels
`include "video_gen_settings.svh"

module video_timing
    import video_gen_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    output      hres_t  h_count_o,
    output      vres_t  v_count_o,
    output      logic   h_visible_o,
    output      logic   v_visible_o,
    output      logic   end_of_line_o,
    output      logic   end_of_frame_o,
    output      logic   end_of_visible_o,
    output      logic   h_blank_o,
    output      logic   v_blank_o,
    output      logic   hsync_o,
    output      logic   vsync_o,
    output      logic   dv_de_o
);

    localparam hres_t H_LAST     = hres_t'(`H_TOTAL - 1);
    localparam hres_t H_SYNC_ON  = hres_t'(`H_FRONT);
    localparam hres_t H_SYNC_OFF = hres_t'(`H_FRONT + `H_SYNC);
    localparam hres_t H_START    = hres_t'(`H_OFFSCREEN);
    localparam vres_t V_LAST     = vres_t'(`V_TOTAL - 1);
    localparam vres_t V_LAST_VIS = vres_t'(`V_OFFSCREEN + `V_VISIBLE - 1);
    localparam vres_t V_SYNC_ON  = vres_t'(`V_FRONT);
    localparam vres_t V_SYNC_OFF = vres_t'(`V_FRONT + `V_SYNC);
    localparam vres_t V_START    = vres_t'(`V_OFFSCREEN);

    logic                               hsync_raw;
    logic                               vsync_raw;
    logic [4:0]                         sig_now;        // blanks, syncs, de at raw count
    logic [`PIXEL_LATENCY-1:0][4:0]     sig_pipe;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o <= '0;
            v_count_o <= '0;
        end else if (end_of_line_o) begin
            h_count_o <= '0;
            v_count_o <= end_of_frame_o ? '0 : v_count_o + 1'b1;
        end else begin
            h_count_o <= h_count_o + 1'b1;
        end
    end

    assign h_visible_o      = (h_count_o >= H_START);
    assign v_visible_o      = (v_count_o >= V_START);
    assign hsync_raw        = (h_count_o >= H_SYNC_ON) && (h_count_o < H_SYNC_OFF);
    assign vsync_raw        = (v_count_o >= V_SYNC_ON) && (v_count_o < V_SYNC_OFF);
    assign end_of_line_o    = (h_count_o == H_LAST);
    assign end_of_frame_o   = end_of_line_o && (v_count_o == V_LAST);
    assign end_of_visible_o = end_of_line_o && (v_count_o == V_LAST_VIS);   // last pixel shown

    assign sig_now = {~h_visible_o, ~v_visible_o, hsync_raw, vsync_raw,
                      h_visible_o && v_visible_o};

    // delay line so blank and sync line up with color_index
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sig_pipe <= {`PIXEL_LATENCY{5'b11000}};        // blanked without sync
        end else begin
            sig_pipe <= {sig_pipe[`PIXEL_LATENCY-2:0], sig_now};
        end
    end

    assign {h_blank_o, v_blank_o, hsync_o, vsync_o, dv_de_o} = sig_pipe[`PIXEL_LATENCY-1];

    // the line counter never passes the last count of the line
    assert property (@(posedge clk) disable iff (reset_i)
        h_count_o <= H_LAST);

endmodule
